/* design/hop_tx_pkg.sv */
package hop_tx_pkg;

  // Datapath widths.
  localparam int PHASE_W   = 24;
  localparam int DATA_W    = 16;
  localparam int GPIO_W    = 12;
  localparam int CODE_W    = 32;
  localparam int HOP_IDX_W = 6;

  // ==================================================
  // Front-panel pin map
  // ==================================================
  localparam int PIN_SYNC    = 0;
  localparam int PIN_HOLD    = 1;  // Input.
  localparam int PIN_LOAD    = 2;
  localparam int PIN_DATA    = 4;
  localparam int PIN_PHI_BAR = 6;
  localparam int PIN_PHI     = 8;
  localparam int PIN_ID      = 10;
  localparam int PIN_TX      = 11;

  localparam logic [GPIO_W-1:0] GPIO_OUT_MASK = GPIO_W'((1 << PIN_SYNC) | (1 << PIN_LOAD) |
    (1 << PIN_DATA) | (1 << PIN_PHI_BAR) | (1 << PIN_PHI) | (1 << PIN_ID) | (1 << PIN_TX));

  // Phase increments.
  localparam logic [PHASE_W-1:0] START_PH_INC = PHASE_W'(8192);
  localparam logic [PHASE_W-1:0] HOP_PH_STEP  = PHASE_W'(131072);
  localparam logic [PHASE_W-1:0] TONE_SPACING = PHASE_W'(4096);

  typedef enum logic [1:0] {
    ST_INIT,
    ST_LOC_SYNC,
    ST_HOP_SYNC,
    ST_HOP_TX
  } hop_state_t;

endpackage

/* design/hop_sequencer.sv */
`timescale 1ns/10ps

module hop_sequencer #(
  parameter int SYNC_LEN = 16384,
  parameter int NUM_HOPS = 64
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             code_we,
  input  logic [hop_tx_pkg::HOP_IDX_W-1:0] code_addr,
  input  logic [hop_tx_pkg::CODE_W-1:0]    code_data,
  input  logic                             hold,
  input  logic                             scan_done,
  output logic                             scan_start,
  output logic [hop_tx_pkg::CODE_W-1:0]    scan_code,
  output logic                             tx_active,
  output logic                             sync_level,
  output logic [hop_tx_pkg::PHASE_W-1:0]   base_inc,
  output logic [hop_tx_pkg::HOP_IDX_W-1:0] hop_index,
  output hop_tx_pkg::hop_state_t           state
);
  import hop_tx_pkg::*;

  localparam int CNT_W = $clog2(SYNC_LEN + 1);
  localparam logic [CNT_W-1:0] SYNC_LAST = CNT_W'(SYNC_LEN - 1);
  localparam logic [HOP_IDX_W-1:0] LAST_HOP = HOP_IDX_W'(NUM_HOPS - 1);

  logic [CODE_W-1:0] code_table [0:(1 << HOP_IDX_W)-1];
  logic [CNT_W-1:0]  sync_cnt;

  // Hop code table written from the host side.
  always_ff @(posedge clk) begin
    if (code_we) code_table[code_addr] <= code_data;
  end

  assign scan_code  = code_table[hop_index];
  assign tx_active  = (state == ST_HOP_TX);
  assign sync_level = (state == ST_LOC_SYNC) || (state == ST_HOP_SYNC);

  // ==================================================
  // Hop state machine
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_INIT;
      sync_cnt   <= '0;
      hop_index  <= '0;
      base_inc   <= START_PH_INC;
      scan_start <= 1'b0;
    end else begin
      scan_start <= 1'b0;
      case (state)
        ST_INIT: begin
          hop_index <= '0;
          base_inc  <= START_PH_INC;
          sync_cnt  <= SYNC_LAST;
          state     <= ST_LOC_SYNC;
        end
        ST_LOC_SYNC: begin
          if (sync_cnt == '0) begin
            sync_cnt <= SYNC_LAST;
            state    <= ST_HOP_SYNC;
          end else begin
            sync_cnt <= sync_cnt - 1'b1;
          end
        end
        ST_HOP_SYNC: begin
          if (!hold) begin  // Count frozen while held.
            if (sync_cnt == '0) begin
              scan_start <= 1'b1;
              state      <= ST_HOP_TX;
            end else begin
              sync_cnt <= sync_cnt - 1'b1;
            end
          end
        end
        ST_HOP_TX: begin
          if (scan_done) begin
            if (hop_index == LAST_HOP) begin
              state <= ST_INIT;
            end else begin
              hop_index <= hop_index + 1'b1;
              base_inc  <= base_inc + HOP_PH_STEP;
              sync_cnt  <= SYNC_LAST;
              state     <= ST_HOP_SYNC;
            end
          end
        end
        default: state <= ST_INIT;
      endcase
    end
  end

endmodule

/* design/scan_loader.sv */
`timescale 1ns/10ps

module scan_loader #(
  parameter int SCAN_DIV = 20
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          scan_start,
  input  logic [hop_tx_pkg::CODE_W-1:0] scan_code,
  output logic                          scan_id,
  output logic                          scan_phi,
  output logic                          scan_phi_bar,
  output logic                          scan_data,
  output logic                          scan_load,
  output logic                          scan_done
);
  import hop_tx_pkg::*;

  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
  localparam int BIT_W = $clog2(CODE_W + 1);
  localparam int HALF  = SCAN_DIV / 2;

  logic              busy;
  logic [DIV_W-1:0]  div_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic [CODE_W-1:0] shift_reg;
  logic              loading;
  logic              first_half;
  logic              period_end;

  assign loading    = (bit_cnt == BIT_W'(CODE_W));  // Bit slot after the last code bit.
  assign first_half = (div_cnt < DIV_W'(HALF));
  assign period_end = (div_cnt == DIV_W'(SCAN_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      scan_done <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      if (!busy) begin
        if (scan_start) begin
          busy    <= 1'b1;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (period_end) begin
        div_cnt <= '0;
        if (loading) begin
          busy      <= 1'b0;
          scan_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // MSB first.
  always_ff @(posedge clk) begin
    if (!busy && scan_start) shift_reg <= scan_code;
    else if (busy && period_end) shift_reg <= {shift_reg[CODE_W-2:0], 1'b0};
  end

  assign scan_id      = busy;
  assign scan_phi     = busy && !loading && first_half;
  assign scan_phi_bar = busy && !loading && !first_half;
  assign scan_data    = busy && !loading && shift_reg[CODE_W-1];
  assign scan_load    = busy && loading;

endmodule

/* design/tone_nco.sv */
`timescale 1ns/10ps

module tone_nco #(
  parameter int CHANNEL = 0
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 tx_active,
  input  logic        [hop_tx_pkg::PHASE_W-1:0] base_inc,
  output logic signed [hop_tx_pkg::DATA_W-1:0]  cos_out,
  output logic signed [hop_tx_pkg::DATA_W-1:0]  sin_out,
  output logic                                 sample_valid
);
  import hop_tx_pkg::*;

  localparam logic [PHASE_W-1:0] CH_OFFSET = PHASE_W'(CHANNEL * TONE_SPACING);
  localparam logic [PHASE_W-1:0] QUARTER   = PHASE_W'(1) << (PHASE_W - 2);

  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] ch_inc;

  // Triangle from the top DATA_W phase bits folded about the half turn.
  function automatic logic signed [DATA_W-1:0] tri_wave(input logic [PHASE_W-1:0] ph);
    logic        [DATA_W-2:0] fold;
    logic signed [DATA_W:0]   val;
    fold = ph[PHASE_W-1] ? ~ph[PHASE_W-2 -: DATA_W-1] : ph[PHASE_W-2 -: DATA_W-1];
    val  = (DATA_W+1)'(2 ** (DATA_W - 1) - 1) - $signed({1'b0, fold, 1'b0});
    return val[DATA_W-1:0];
  endfunction

  assign ch_inc = base_inc + CH_OFFSET;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase        <= '0;
      sample_valid <= 1'b0;
    end else begin
      phase        <= tx_active ? phase + ch_inc : '0;
      sample_valid <= tx_active;
    end
  end

  always_ff @(posedge clk) begin
    cos_out <= tri_wave(phase);
    sin_out <= tri_wave(phase - QUARTER);  // Quarter turn behind.
  end

endmodule

/* design/tone_combiner.sv */
`timescale 1ns/10ps

module tone_combiner #(
  parameter int NUM_TONES = 4
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [NUM_TONES*hop_tx_pkg::DATA_W-1:0]    ch_cos,
  input  logic [NUM_TONES*hop_tx_pkg::DATA_W-1:0]    ch_sin,
  input  logic [NUM_TONES-1:0]                       ch_valid,
  output logic [hop_tx_pkg::DATA_W-1:0]              itx,
  output logic [hop_tx_pkg::DATA_W-1:0]              qtx,
  output logic                                       tx_valid
);
  import hop_tx_pkg::*;

  localparam int SHIFT = $clog2(NUM_TONES);
  localparam int SUM_W = DATA_W + SHIFT;

  logic signed [SUM_W-1:0] sum_i;
  logic signed [SUM_W-1:0] sum_q;

  // Full precision sum of all channels.
  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int k = 0; k < NUM_TONES; k++) begin
      sum_i = sum_i + $signed(ch_cos[k*DATA_W +: DATA_W]);
      sum_q = sum_q + $signed(ch_sin[k*DATA_W +: DATA_W]);
    end
  end

  always_ff @(posedge clk) begin
    itx <= DATA_W'(sum_i >>> SHIFT);  // Scale back by channel count.
    qtx <= DATA_W'(sum_q >>> SHIFT);
  end

  always_ff @(posedge clk) begin
    if (reset) tx_valid <= 1'b0;
    else tx_valid <= &ch_valid;
  end

endmodule

/* design/gpio_mapper.sv */
`timescale 1ns/10ps

module gpio_mapper (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sync_level,
  input  logic                          tx_active,
  input  logic                          scan_id,
  input  logic                          scan_phi,
  input  logic                          scan_phi_bar,
  input  logic                          scan_data,
  input  logic                          scan_load,
  input  logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_in,
  output logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_out,
  output logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_ddr,
  output logic                          hold
);
  import hop_tx_pkg::*;

  logic [GPIO_W-1:0] pins;
  logic              hold_meta;

  always_comb begin
    pins               = '0;
    pins[PIN_SYNC]     = sync_level;
    pins[PIN_LOAD]     = scan_load;
    pins[PIN_DATA]     = scan_data;
    pins[PIN_PHI_BAR]  = scan_phi_bar;
    pins[PIN_PHI]      = scan_phi;
    pins[PIN_ID]       = scan_id;
    pins[PIN_TX]       = tx_active;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fp_gpio_out <= '0;
      fp_gpio_ddr <= '0;
      hold_meta   <= 1'b0;
      hold        <= 1'b0;
    end else begin
      fp_gpio_out <= pins & GPIO_OUT_MASK;
      fp_gpio_ddr <= GPIO_OUT_MASK;
      hold_meta   <= fp_gpio_in[PIN_HOLD];  // Two-flop synchronizer.
      hold        <= hold_meta;
    end
  end

endmodule

/* design/hop_tx_top.sv */
`timescale 1ns/10ps

module hop_tx_top #(
  parameter int NUM_TONES = 4,
  parameter int SYNC_LEN  = 16384,
  parameter int NUM_HOPS  = 64,
  parameter int SCAN_DIV  = 20
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             code_we,
  input  logic [hop_tx_pkg::HOP_IDX_W-1:0] code_addr,
  input  logic [hop_tx_pkg::CODE_W-1:0]    code_data,
  input  logic [hop_tx_pkg::GPIO_W-1:0]    fp_gpio_in,
  output logic [hop_tx_pkg::GPIO_W-1:0]    fp_gpio_out,
  output logic [hop_tx_pkg::GPIO_W-1:0]    fp_gpio_ddr,
  output logic [hop_tx_pkg::DATA_W-1:0]    itx,
  output logic [hop_tx_pkg::DATA_W-1:0]    qtx,
  output logic                             tx_valid,
  output logic [hop_tx_pkg::HOP_IDX_W-1:0] hop_index,
  output hop_tx_pkg::hop_state_t           state
);
  import hop_tx_pkg::*;

  logic                        hold, scan_start, scan_done;
  logic [CODE_W-1:0]           scan_code;
  logic                        tx_active, sync_level;
  logic [PHASE_W-1:0]          base_inc;
  logic                        scan_id, scan_phi, scan_phi_bar, scan_data, scan_load;
  logic [NUM_TONES*DATA_W-1:0] ch_cos, ch_sin;
  logic [NUM_TONES-1:0]        ch_valid;

  hop_sequencer #(.SYNC_LEN(SYNC_LEN), .NUM_HOPS(NUM_HOPS)) u_hop_sequencer (
    .clk, .reset, .code_we, .code_addr, .code_data, .hold, .scan_done,
    .scan_start, .scan_code, .tx_active, .sync_level, .base_inc, .hop_index, .state
  );

  scan_loader #(.SCAN_DIV(SCAN_DIV)) u_scan_loader (
    .clk, .reset, .scan_start, .scan_code, .scan_id, .scan_phi, .scan_phi_bar,
    .scan_data, .scan_load, .scan_done
  );

  // ==================================================
  // Tone bank
  // ==================================================
  for (genvar k = 0; k < NUM_TONES; k++) begin : g_tone
    tone_nco #(.CHANNEL(k)) u_tone_nco (
      .clk, .reset, .tx_active, .base_inc,
      .cos_out      (ch_cos[k*DATA_W +: DATA_W]),
      .sin_out      (ch_sin[k*DATA_W +: DATA_W]),
      .sample_valid (ch_valid[k])
    );
  end

  tone_combiner #(.NUM_TONES(NUM_TONES)) u_tone_combiner (
    .clk, .reset, .ch_cos, .ch_sin, .ch_valid, .itx, .qtx, .tx_valid
  );

  gpio_mapper u_gpio_mapper (
    .clk, .reset, .sync_level, .tx_active, .scan_id, .scan_phi, .scan_phi_bar,
    .scan_data, .scan_load, .fp_gpio_in, .fp_gpio_out, .fp_gpio_ddr, .hold
  );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;  // 100 ns period.

endmodule

/* sim/hop_tx_chk.sv */
`timescale 1ns/10ps

module hop_tx_chk (
  input logic                          clk,
  input logic                          reset,
  input logic                          scan_phi,
  input logic                          scan_phi_bar,
  input logic                          tx_active,
  input logic                          tx_valid,
  input logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_out
);
  import hop_tx_pkg::*;

  // The two scan clock phases never overlap.
  phi_overlap: assert property (@(posedge clk) disable iff (reset)
    !(scan_phi && scan_phi_bar))
    else $error("Scan phi and phi_bar are high together.");

  // NCO register plus combiner register.
  valid_delay: assert property (@(posedge clk) disable iff (reset)
    tx_valid == $past(tx_active, 2))
    else $error("tx_valid does not follow tx_active by two cycles.");

  input_pins_low: assert property (@(posedge clk) disable iff (reset)
    (fp_gpio_out & ~GPIO_OUT_MASK) == '0)
    else $error("Front-panel output drives a pin outside the output mask.");

endmodule

bind hop_tx_top hop_tx_chk u_hop_tx_chk (
  .clk          (clk),
  .reset        (reset),
  .scan_phi     (scan_phi),
  .scan_phi_bar (scan_phi_bar),
  .tx_active    (tx_active),
  .tx_valid     (tx_valid),
  .fp_gpio_out  (fp_gpio_out)
);

/* sim/hop_tx_tb.sv */
`timescale 1ns/10ps

module hop_tx_tb;
  import hop_tx_pkg::*;

  localparam int NUM_TONES  = 4;
  localparam int SYNC_LEN   = 8;
  localparam int NUM_HOPS   = 3;
  localparam int SCAN_DIV   = 4;
  localparam int WAIT_LIMIT = 1000;
  localparam int TX_CYCLES  = (CODE_W + 1) * SCAN_DIV + 2;
  localparam int HOLD_AT    = SYNC_LEN + 2;  // Lands inside ST_HOP_SYNC.
  localparam int unsigned PH_MASK = 32'h00ff_ffff;
  localparam int unsigned QUARTER = 32'h0040_0000;

  logic                 clk;
  logic                 reset;
  logic                 code_we;
  logic [HOP_IDX_W-1:0] code_addr;
  logic [CODE_W-1:0]    code_data;
  logic [GPIO_W-1:0]    fp_gpio_in;
  logic [GPIO_W-1:0]    fp_gpio_out;
  logic [GPIO_W-1:0]    fp_gpio_ddr;
  logic [DATA_W-1:0]    itx;
  logic [DATA_W-1:0]    qtx;
  logic                 tx_valid;
  logic [HOP_IDX_W-1:0] hop_index;
  hop_state_t           state;

  logic [31:0]       lfsr;
  logic [CODE_W-1:0] hop_codes [0:NUM_HOPS-1];
  bit                run_over;

  tb_clk_gen u_tb_clk_gen (.clk(clk));

  hop_tx_top #(
    .NUM_TONES (NUM_TONES),
    .SYNC_LEN  (SYNC_LEN),
    .NUM_HOPS  (NUM_HOPS),
    .SCAN_DIV  (SCAN_DIV)
  ) u_hop_tx_top (
    .clk, .reset, .code_we, .code_addr, .code_data, .fp_gpio_in, .fp_gpio_out,
    .fp_gpio_ddr, .itx, .qtx, .tx_valid, .hop_index, .state
  );

  // ==================================================
  // Error handling and waits
  // ==================================================
  task automatic abort_run();
    run_over = 1'b1;
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic value_error(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic wait_timeout(input string what);
    $display("Timed out while waiting for %s.", what);
    abort_run();
  endtask

  // Inputs change and outputs are read 1 ns after the edge.
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_pin(input int pin, input logic level, input string what);
    int n;
    n = 0;
    while (fp_gpio_out[pin] !== level) begin
      step();
      n++;
      if (n > WAIT_LIMIT) wait_timeout(what);
    end
  endtask

  task automatic wait_state(input hop_state_t target, input bit equal, input string what);
    int n;
    n = 0;
    while ((state == target) != equal) begin
      step();
      n++;
      if (n > WAIT_LIMIT) wait_timeout(what);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (10) step();
    reset = 1'b0;
  endtask

  // ==================================================
  // Stimulus and reference models
  // ==================================================
  function automatic logic [CODE_W-1:0] draw_code();
    logic [CODE_W-1:0] code;
    code = '0;
    for (int b = 0; b < CODE_W; b++) begin
      code = {code[CODE_W-2:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);  // Galois step.
    end
    return code;
  endfunction

  task automatic write_codes();
    for (int h = 0; h < NUM_HOPS; h++) begin
      hop_codes[h] = draw_code();
      code_we   = 1'b1;
      code_addr = HOP_IDX_W'(h);
      code_data = hop_codes[h];
      step();
    end
    code_we = 1'b0;
  endtask

  // Triangle on the top 16 phase bits from +32767 at zero to -32767 at the half turn.
  function automatic int tri_ref(input int unsigned ph);
    int top;
    top = int'((ph >> 8) & 32'hffff);
    if (top < 32768) return 32767 - 2 * top;
    else return 32767 - 2 * (65535 - top);
  endfunction

  task automatic tone_model(input int hop, input int n, output int exp_i, output int exp_q);
    int unsigned inc;
    int unsigned ph;
    int          sum_i;
    int          sum_q;
    sum_i = 0;
    sum_q = 0;
    for (int k = 0; k < NUM_TONES; k++) begin
      inc = (int'(START_PH_INC) + hop * int'(HOP_PH_STEP) + k * int'(TONE_SPACING)) & PH_MASK;
      ph  = (n * inc) & PH_MASK;
      sum_i += tri_ref(ph);
      sum_q += tri_ref((ph - QUARTER) & PH_MASK);
    end
    exp_i = sum_i >>> $clog2(NUM_TONES);
    exp_q = sum_q >>> $clog2(NUM_TONES);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_state();
    reset = 1'b1;
    repeat (10) begin
      step();
      assert (fp_gpio_out == '0 && fp_gpio_ddr == '0 && tx_valid == 1'b0)
        else value_error("Outputs are not cleared during reset.");
      assert (state == ST_INIT)
        else value_error($sformatf("State %s during reset.", state.name()));
    end
    reset = 1'b0;
    step();
    assert (fp_gpio_ddr == GPIO_OUT_MASK)
      else value_error($sformatf("Directions %h, expected %h.", fp_gpio_ddr, GPIO_OUT_MASK));
    assert (state == ST_LOC_SYNC)
      else value_error($sformatf("State %s after ST_INIT.", state.name()));
  endtask

  task automatic test_sync_timing(input int hold_len);
    int high_cycles;
    apply_reset();
    wait_pin(PIN_SYNC, 1'b1, "the sync pin to rise");
    high_cycles = 0;
    while (fp_gpio_out[PIN_SYNC]) begin
      high_cycles++;
      if (hold_len > 0 && high_cycles == HOLD_AT) fp_gpio_in[PIN_HOLD] = 1'b1;
      if (high_cycles == HOLD_AT + hold_len) fp_gpio_in[PIN_HOLD] = 1'b0;
      step();
      if (high_cycles > WAIT_LIMIT) wait_timeout("the sync pin to fall");
    end
    fp_gpio_in[PIN_HOLD] = 1'b0;
    assert (high_cycles == 2 * SYNC_LEN + hold_len)
      else value_error($sformatf("Sync pin high %0d cycles with %0d hold cycles, expected %0d.",
        high_cycles, hold_len, 2 * SYNC_LEN + hold_len));
  endtask

  task automatic test_scan_shift();
    logic [CODE_W-1:0] rebuilt;
    logic              phi_prev;
    logic              last_load;
    int                bits;
    int                load_cycles;
    int                n;
    write_codes();
    apply_reset();
    for (int h = 0; h < NUM_HOPS; h++) begin
      wait_pin(PIN_ID, 1'b1, "the chip id pin to rise");
      rebuilt     = '0;
      phi_prev    = 1'b0;
      last_load   = 1'b0;
      bits        = 0;
      load_cycles = 0;
      n           = 0;
      while (fp_gpio_out[PIN_ID]) begin
        if (fp_gpio_out[PIN_PHI] && !phi_prev) begin
          assert (load_cycles == 0) else value_error("Scan clock runs after the load strobe.");
          rebuilt = {rebuilt[CODE_W-2:0], fp_gpio_out[PIN_DATA]};
          bits++;
        end
        if (fp_gpio_out[PIN_LOAD]) begin
          assert (bits == CODE_W)
            else value_error($sformatf("Load strobe after %0d bits.", bits));
          load_cycles++;
        end
        phi_prev  = fp_gpio_out[PIN_PHI];
        last_load = fp_gpio_out[PIN_LOAD];
        step();
        n++;
        if (n > WAIT_LIMIT) wait_timeout("the chip id pin to fall");
      end
      assert (rebuilt == hop_codes[h] && bits == CODE_W)
        else value_error($sformatf("Hop %0d shifted %h in %0d bits, expected %h.",
          h, rebuilt, bits, hop_codes[h]));
      assert (load_cycles == SCAN_DIV && last_load)
        else value_error($sformatf("Hop %0d load strobe %0d cycles, expected %0d at the end.",
          h, load_cycles, SCAN_DIV));
    end
  endtask

  task automatic test_tone_samples();
    int n;
    int exp_i;
    int exp_q;
    int got_i;
    int got_q;
    apply_reset();
    for (int h = 0; h < NUM_HOPS; h++) begin
      n = 0;
      while (!tx_valid) begin
        step();
        n++;
        if (n > WAIT_LIMIT) wait_timeout("tx_valid to rise");
      end
      n = 0;
      while (tx_valid) begin
        tone_model(h, n, exp_i, exp_q);
        got_i = $signed(itx);
        got_q = $signed(qtx);
        assert (got_i == exp_i && got_q == exp_q)
          else value_error($sformatf("Hop %0d sample %0d: I/Q %0d/%0d, expected %0d/%0d.",
            h, n, got_i, got_q, exp_i, exp_q));
        n++;
        step();
        if (n > WAIT_LIMIT) wait_timeout("tx_valid to fall");
      end
      assert (n == TX_CYCLES)
        else value_error($sformatf("Hop %0d gave %0d samples, expected %0d.", h, n, TX_CYCLES));
    end
  endtask

  task automatic test_hop_sequence();
    logic [PHASE_W-1:0] exp_inc;
    apply_reset();
    for (int h = 0; h < NUM_HOPS; h++) begin
      wait_state(ST_HOP_TX, 1'b1, "the transmit state");
      exp_inc = PHASE_W'(int'(START_PH_INC) + h * int'(HOP_PH_STEP));
      assert (hop_index == HOP_IDX_W'(h) && u_hop_tx_top.base_inc == exp_inc)
        else value_error($sformatf("Hop index %0d, increment %0d, expected %0d, %0d.",
          hop_index, u_hop_tx_top.base_inc, h, exp_inc));
      wait_state(ST_HOP_TX, 1'b0, "the end of the transmit state");
    end
    assert (state == ST_INIT)
      else value_error($sformatf("State %s after the last hop.", state.name()));
    step();
    assert (state == ST_LOC_SYNC && hop_index == '0 && u_hop_tx_top.base_inc == START_PH_INC)
      else value_error("Sequence did not restart at hop 0.");
    wait_state(ST_HOP_TX, 1'b1, "the first transmit state of the new sequence");
    assert (hop_index == '0)
      else value_error($sformatf("Hop index %0d on restart.", hop_index));
  endtask

  initial begin
    lfsr       = 32'h0e26f427;
    run_over   = 1'b0;
    reset      = 1'b1;
    code_we    = 1'b0;
    code_addr  = '0;
    code_data  = '0;
    fp_gpio_in = '0;
    test_reset_state();
    test_sync_timing(0);
    test_sync_timing(3);
    test_scan_shift();
    test_tone_samples();
    test_hop_sequence();
    run_over = 1'b1;
    $display("=== PASS ===");
    $finish;
  end

  final begin
    if (!run_over) $display("=== FAIL ===");
  end

endmodule

/* tb.f */
design/hop_tx_pkg.sv
design/hop_sequencer.sv
design/scan_loader.sv
design/tone_nco.sv
design/tone_combiner.sv
design/gpio_mapper.sv
design/hop_tx_top.sv
sim/tb_clk_gen.sv
sim/hop_tx_chk.sv
sim/hop_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module hop_tx_tb -o Vhop_tx_tb

./obj_dir/Vhop_tx_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed."
  exit 1
fi
echo "Simulation passed."
